/* logic/clause_picker_config.svh */
// sizing macros for the unsat clause picker
// included by the type package and by every module that sizes a memory or a slice
// all widths follow from these values, change them here only
`ifndef CLAUSE_PICKER_CONFIG_SVH
`define CLAUSE_PICKER_CONFIG_SVH

// buffer slots and 1/m table entries
`define BUF_DEPTH    2048
// position and count width, so at most 2047 live entries
`define BUF_ADDR_W   11

// one clause identifier
`define CLAUSE_ID_W  16

// incoming random word and the slice taken from it
`define RAND_W       32
`define RAND_SLICE_W 18
`define RAND_OFFSET  10

// reciprocal width, every bit is fraction
`define RECIP_W      32

`endif

/* logic/sat_types_pkg.sv */
// plain vector types shared by the clause picker blocks
// widths come from the config header
// modules refer to these by sat_types_pkg::name

`include "clause_picker_config.svh"

package sat_types_pkg;

    // clause identifier as stored in the buffer
    typedef logic [`CLAUSE_ID_W-1:0] clause_id_t;

    // buffer position, also used for the entry count
    typedef logic [`BUF_ADDR_W-1:0] buf_pos_t;

    // raw random word from the generator
    typedef logic [`RAND_W-1:0] rand_word_t;

    // bits of the random word that feed the modulo
    typedef logic [`RAND_SLICE_W-1:0] rand_slice_t;

    // fixed point 1/m
    // entry m holds ceil(2^32 / m)
    typedef logic [`RECIP_W-1:0] recip_t;

endpackage

/* logic/picker_msg_pkg.sv */
// message formats between the solver core and the clause picker
// buffer requests, table load words and pick results
// field types come from sat_types_pkg

package picker_msg_pkg;

    // buffer opcode
    // nop means no request this cycle
    typedef enum logic [1:0] {
        BUF_NOP    = 2'd0,
        BUF_ADD    = 2'd1,
        BUF_REMOVE = 2'd2
    } buf_op_e;

    // one buffer request
    // id used by add, pos used by remove
    typedef struct packed {
        buf_op_e                  op;
        sat_types_pkg::clause_id_t id;
        sat_types_pkg::buf_pos_t   pos;
    } buf_req_t;

    // one 1/m table write
    typedef struct packed {
        sat_types_pkg::buf_pos_t addr;
        sat_types_pkg::recip_t   value;
    } recip_load_t;

    // chosen slot and what it holds
    typedef struct packed {
        sat_types_pkg::buf_pos_t   pos;
        sat_types_pkg::clause_id_t id;
    } pick_result_t;

endpackage

/* logic/recip_table.sv */
// 1/m reciprocal table for the index selector
// single port block ram style memory with registered output
// written by the load path and read by the pick path through the same address
// a read during a write returns the old contents

`timescale 1ns/1ps

`include "clause_picker_config.svh"

module recip_table (
    input  logic                    clk,
    input  logic                    en_i,
    input  logic                    we_i,
    input  sat_types_pkg::buf_pos_t addr_i,
    input  sat_types_pkg::recip_t   data_i,
    output sat_types_pkg::recip_t   data_o
);

    // entry 0 never read with a valid pick
    sat_types_pkg::recip_t mem [`BUF_DEPTH];

    // write port
    always_ff @(posedge clk) begin
        if (en_i) begin
            if (we_i) begin
                mem[addr_i] <= data_i;
            end
        end
    end

    // registered read
    // holds its value while disabled
    always_ff @(posedge clk) begin
        if (en_i) begin
            data_o <= mem[addr_i];
        end
    end

endmodule

/* logic/unsat_index_selector.sv */
// picks a uniform position below the current count without a divider
// pos = slice - floor(slice * recip(count)) * count, i.e. slice mod count
// three registered stages, position valid three cycles after the pick
// the 1/m table lives here and shares its address with the load path

`timescale 1ns/1ps

`include "clause_picker_config.svh"

module unsat_index_selector (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        pick_i,
    input  sat_types_pkg::rand_word_t   rand_i,
    input  sat_types_pkg::buf_pos_t     count_i,
    input  logic                        recip_we_i,
    input  picker_msg_pkg::recip_load_t recip_load_i,
    output sat_types_pkg::buf_pos_t     pos_o
);

    logic                      tbl_en;
    sat_types_pkg::buf_pos_t   tbl_addr;
    sat_types_pkg::recip_t     recip;

    sat_types_pkg::rand_slice_t slice1;
    sat_types_pkg::rand_slice_t slice2;
    sat_types_pkg::buf_pos_t    count1;
    sat_types_pkg::buf_pos_t    count2;

    // slice times reciprocal
    // integer part on top
    logic [`RAND_SLICE_W+`RECIP_W-1:0] product2;
    sat_types_pkg::rand_slice_t        quotient;
    // remainder fits in the count width
    sat_types_pkg::rand_slice_t        rem;

    // load address wins
    // loads and picks never overlap
    assign tbl_en   = recip_we_i | pick_i;
    assign tbl_addr = recip_we_i ? recip_load_i.addr : count_i;

    recip_table u_recip_table (
        .clk    (clk),
        .en_i   (tbl_en),
        .we_i   (recip_we_i),
        .addr_i (tbl_addr),
        .data_i (recip_load_i.value),
        .data_o (recip)
    );

    // quotient is exact for an 18 bit slice and counts below 2^11
    assign quotient = product2[`RECIP_W +: `RAND_SLICE_W];
    // computed mod 2^18
    // true result is below count
    assign rem      = slice2 - quotient * count2;

    // datapath stages
    always_ff @(posedge clk) begin
        // stage 1 alongside the table read
        slice1   <= rand_i[`RAND_OFFSET +: `RAND_SLICE_W];
        // stage 2
        slice2   <= slice1;
        product2 <= slice1 * recip;
    end

    // count pipe and position output
    always_ff @(posedge clk) begin
        if (reset) begin
            count1 <= '0;
            count2 <= '0;
            pos_o  <= '0;
        end else begin
            count1 <= count_i;
            count2 <= count1;
            // 1/1 does not fit in the table
            // force slot 0
            if (count2 == sat_types_pkg::buf_pos_t'(1)) begin
                pos_o <= '0;
            end else begin
                pos_o <= rem[`BUF_ADDR_W-1:0];
            end
        end
    end

endmodule

/* logic/unsat_clause_buffer.sv */
// store of currently unsatisfied clause identifiers
// add appends at slot count, remove moves the last entry into the freed slot
// both take one cycle, full adds and out of range removes are dropped
// the read port registers the identifier at rd_pos_i every cycle and sees
// a write landing on the same edge

`timescale 1ns/1ps

`include "clause_picker_config.svh"

module unsat_clause_buffer (
    input  logic                      clk,
    input  logic                      reset,
    input  picker_msg_pkg::buf_req_t  req_i,
    input  sat_types_pkg::buf_pos_t   rd_pos_i,
    output sat_types_pkg::clause_id_t rd_id_o,
    output sat_types_pkg::buf_pos_t   count_o
);

    sat_types_pkg::clause_id_t mem [`BUF_DEPTH];

    sat_types_pkg::buf_pos_t   count_q;
    sat_types_pkg::buf_pos_t   last_pos;
    logic                      do_add;
    logic                      do_remove;

    // the single write this cycle
    logic                      wr_en;
    sat_types_pkg::buf_pos_t   wr_pos;
    sat_types_pkg::clause_id_t wr_data;

    assign last_pos = count_q - 1'b1;

    // all ones count means full, 2047 entries
    assign do_add    = (req_i.op == picker_msg_pkg::BUF_ADD) && (count_q != '1);
    assign do_remove = (req_i.op == picker_msg_pkg::BUF_REMOVE) && (req_i.pos < count_q);

    always_comb begin
        wr_en = do_add | do_remove;
        if (do_add) begin
            wr_pos  = count_q;
            wr_data = req_i.id;
        end else begin
            // swap remove, last entry fills the hole
            wr_pos  = req_i.pos;
            wr_data = mem[last_pos];
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_pos] <= wr_data;
        end
    end

    // entry count
    always_ff @(posedge clk) begin
        if (reset) begin
            count_q <= '0;
        end else if (do_add) begin
            count_q <= count_q + 1'b1;
        end else if (do_remove) begin
            count_q <= last_pos;
        end
    end

    // registered read
    // forward a same edge write so the result reflects it
    always_ff @(posedge clk) begin
        if (wr_en && (wr_pos == rd_pos_i)) begin
            rd_id_o <= wr_data;
        end else begin
            rd_id_o <= mem[rd_pos_i];
        end
    end

    assign count_o = count_q;

endmodule

/* logic/unsat_clause_picker.sv */
// clause picker top level for the local search solver core
// buffer requests and table loads come straight in, a pick strobe with a
// random word returns a uniformly chosen clause four cycles later
// a pick on an empty buffer only sets the sticky error flag

`timescale 1ns/1ps

module unsat_clause_picker (
    input  logic                         clk,
    input  logic                         reset,
    input  picker_msg_pkg::buf_req_t     buf_req_i,
    input  logic                         recip_we_i,
    input  picker_msg_pkg::recip_load_t  recip_load_i,
    input  logic                         pick_i,
    input  sat_types_pkg::rand_word_t    rand_i,
    input  logic                         clear_err_i,
    output logic                         pick_valid_o,
    output picker_msg_pkg::pick_result_t pick_o,
    output sat_types_pkg::buf_pos_t      count_o,
    output logic                         err_empty_o
);

    sat_types_pkg::buf_pos_t   count;
    sat_types_pkg::buf_pos_t   sel_pos;
    sat_types_pkg::buf_pos_t   pos_q;
    sat_types_pkg::clause_id_t rd_id;

    logic       pick_empty;
    logic       pick_ok;
    // one bit per pipeline stage
    logic [3:0] valid_q;

    unsat_clause_buffer u_buffer (
        .clk      (clk),
        .reset    (reset),
        .req_i    (buf_req_i),
        .rd_pos_i (sel_pos),
        .rd_id_o  (rd_id),
        .count_o  (count)
    );

    unsat_index_selector u_selector (
        .clk          (clk),
        .reset        (reset),
        .pick_i       (pick_i),
        .rand_i       (rand_i),
        .count_i      (count),
        .recip_we_i   (recip_we_i),
        .recip_load_i (recip_load_i),
        .pos_o        (sel_pos)
    );

    assign pick_empty = pick_i && (count == '0);
    assign pick_ok    = pick_i && (count != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q     <= '0;
            err_empty_o <= 1'b0;
        end else begin
            valid_q <= {valid_q[2:0], pick_ok};
            // set wins over clear
            if (pick_empty) begin
                err_empty_o <= 1'b1;
            end else if (clear_err_i) begin
                err_empty_o <= 1'b0;
            end
        end
    end

    // position rides next to the buffer read data
    always_ff @(posedge clk) begin
        pos_q <= sel_pos;
    end

    assign pick_valid_o = valid_q[3];
    assign pick_o.pos   = pos_q;
    assign pick_o.id    = rd_id;
    assign count_o      = count;

endmodule

/* testbench/unsat_clause_picker_asserts.sv */
// concurrent checks on the clause picker top level
// bound into every unsat_clause_picker instance at the end of this file
// fires $error on pick latency, position range, count step and load overlap

`timescale 1ns/1ps

module unsat_clause_picker_asserts (
    input logic                         clk,
    input logic                         reset,
    input logic                         pick_i,
    input logic                         recip_we_i,
    input logic                         pick_valid_o,
    input picker_msg_pkg::pick_result_t pick_o,
    input sat_types_pkg::buf_pos_t      count_o
);

    // nonempty pick comes back four edges later
    a_pick_latency: assert property (@(posedge clk) disable iff (reset)
        (pick_i && (count_o != '0)) |-> ##4 pick_valid_o)
        else $error("pick on a nonempty buffer gave no result four cycles later");

    // chosen slot lies below the count seen with the pick
    a_pos_range: assert property (@(posedge clk) disable iff (reset)
        pick_valid_o |-> (pick_o.pos < $past(count_o, 4)))
        else $error("picked position is not below the count at the pick");

    // count moves by at most one per cycle
    // so a full buffer never wraps to zero
    a_count_step: assert property (@(posedge clk) disable iff (reset)
        (int'(count_o) <= int'($past(count_o)) + 1)
        && (int'(count_o) + 1 >= int'($past(count_o))))
        else $error("entry count jumped by more than one in a cycle");

    // table address mux is shared
    a_no_load_pick: assert property (@(posedge clk) disable iff (reset)
        !(recip_we_i && pick_i))
        else $error("table load and pick in the same cycle");

endmodule

bind unsat_clause_picker unsat_clause_picker_asserts u_asserts (
    .clk          (clk),
    .reset        (reset),
    .pick_i       (pick_i),
    .recip_we_i   (recip_we_i),
    .pick_valid_o (pick_valid_o),
    .pick_o       (pick_o),
    .count_o      (count_o)
);

/* testbench/unsat_clause_picker_tb.sv */
// self checking testbench for the unsat clause picker
// loads the 1/m table, then runs LCG driven buffer traffic and picks
// a model mirrors the buffer, the sticky flag and the four edge pick pipe
// outputs are compared at the falling edge

`timescale 1ns/1ps

`include "clause_picker_config.svh"

module unsat_clause_picker_tb;

    // phases add up to about 10000 cycles
    localparam int TIMEOUT_CYCLES = 12000;
    localparam int MAX_COUNT      = `BUF_DEPTH - 1;

    logic                         clk;
    logic                         reset;
    picker_msg_pkg::buf_req_t     buf_req;
    logic                         recip_we;
    picker_msg_pkg::recip_load_t  recip_load;
    logic                         pick;
    sat_types_pkg::rand_word_t    rand_word;
    logic                         clear_err;
    logic                         pick_valid;
    picker_msg_pkg::pick_result_t pick_res;
    sat_types_pkg::buf_pos_t      count;
    logic                         err_empty;

    // model of buffer contents and pick pipe
    sat_types_pkg::clause_id_t m_ids [`BUF_DEPTH];
    int   m_count;
    logic m_err;
    logic m_v [3];
    int   m_p [3];
    logic exp_valid;
    int   exp_pos;
    int   exp_id;

    logic [31:0] lcg_state;
    int          cnt_seen;
    int          cycle;
    int          checks;
    int          errors;
    string       phase;

    unsat_clause_picker dut0 (
        .clk          (clk),
        .reset        (reset),
        .buf_req_i    (buf_req),
        .recip_we_i   (recip_we),
        .recip_load_i (recip_load),
        .pick_i       (pick),
        .rand_i       (rand_word),
        .clear_err_i  (clear_err),
        .pick_valid_o (pick_valid),
        .pick_o       (pick_res),
        .count_o      (count),
        .err_empty_o  (err_empty)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // ceil(2^32 / m)
    // m of 1 wraps to zero
    function automatic sat_types_pkg::recip_t recip_ceil(input int m);
        logic [63:0] q;
        q = (64'd1 << 32) + 64'(m) - 64'd1;
        q = q / 64'(m);
        return q[31:0];
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    // one cycle of stimulus
    // new random word every call
    task automatic drive_cycle(input picker_msg_pkg::buf_op_e op, input int pos,
                               input logic pk, input logic clr);
        logic [31:0] r;
        r = next_rand();
        @(posedge clk);
        buf_req.op  <= op;
        buf_req.id  <= r[31:16];
        buf_req.pos <= sat_types_pkg::buf_pos_t'(pos);
        pick        <= pk;
        rand_word   <= next_rand();
        clear_err   <= clr;
    endtask

    // model update with the inputs sampled at this edge
    always @(posedge clk) begin
        int cnt_before;
        int slice;
        if (reset) begin
            m_count   = 0;
            m_err     = 1'b0;
            exp_valid = 1'b0;
            for (int i = 0; i < 3; i++) begin
                m_v[i] = 1'b0;
                m_p[i] = 0;
            end
        end else begin
            cnt_before = m_count;
            if (buf_req.op == picker_msg_pkg::BUF_ADD && m_count < MAX_COUNT) begin
                m_ids[m_count] = buf_req.id;
                m_count++;
            end else if (buf_req.op == picker_msg_pkg::BUF_REMOVE && buf_req.pos < m_count) begin
                m_ids[buf_req.pos] = m_ids[m_count - 1];
                m_count--;
            end
            if (pick && cnt_before == 0) begin
                m_err = 1'b1;
            end else if (clear_err) begin
                m_err = 1'b0;
            end
            // id read after this edge's request
            exp_valid = m_v[2];
            exp_pos   = m_p[2];
            exp_id    = m_ids[m_p[2]];
            m_v[2] = m_v[1];
            m_p[2] = m_p[1];
            m_v[1] = m_v[0];
            m_p[1] = m_p[0];
            slice  = int'(rand_word[`RAND_OFFSET +: `RAND_SLICE_W]);
            m_v[0] = pick && cnt_before != 0;
            m_p[0] = (cnt_before != 0) ? slice % cnt_before : 0;
        end
    end

    always @(negedge clk) begin
        if (!reset) begin
            check({phase, " count"}, m_count, count);
            check({phase, " err_empty"}, m_err, err_empty);
            if (pick_valid !== exp_valid) begin
                errors++;
                if (exp_valid) begin
                    $display("%s: pick result missing at cycle %0d", phase, cycle);
                end else begin
                    $display("%s: pick_valid_o raised with no pick at cycle %0d", phase, cycle);
                end
            end else if (exp_valid) begin
                check({phase, " pos"}, exp_pos, pick_res.pos);
                check({phase, " id"}, exp_id, pick_res.id);
            end
            cnt_seen = count;
        end
    end

    // run limit in clock cycles
    initial begin
        cycle = 0;
        while (cycle < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle++;
        end
        $display("timeout, the test did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        logic [31:0]             r;
        picker_msg_pkg::buf_op_e op;
        clk        = 1'b0;
        reset      = 1'b1;
        buf_req    = '0;
        recip_we   = 1'b0;
        recip_load = '0;
        pick       = 1'b0;
        rand_word  = '0;
        clear_err  = 1'b0;
        lcg_state  = 32'h77e5_7bc0;
        cnt_seen   = 0;
        checks     = 0;
        errors     = 0;
        phase      = "reset";
        repeat (3) @(posedge clk);
        reset <= 1'b0;

        phase = "table_load";
        for (int m = 1; m <= MAX_COUNT; m++) begin
            @(posedge clk);
            recip_we         <= 1'b1;
            recip_load.addr  <= sat_types_pkg::buf_pos_t'(m);
            recip_load.value <= recip_ceil(m);
        end
        @(posedge clk);
        recip_we <= 1'b0;

        // adds favoured so the count climbs
        // some removes fall out of range
        phase = "buffer_maint";
        for (int i = 0; i < 1500; i++) begin
            r  = next_rand();
            op = (r[31:30] != 2'b00) ? picker_msg_pkg::BUF_ADD : picker_msg_pkg::BUF_REMOVE;
            drive_cycle(op, int'(r[15:0]) % (cnt_seen + 2), 1'b0, 1'b0);
        end

        // back to back picks with updates at every pipe offset
        phase = "pick_mix";
        for (int i = 0; i < 2000; i++) begin
            r = next_rand();
            case (r[31:29])
                3'd0, 3'd1, 3'd2: op = picker_msg_pkg::BUF_ADD;
                3'd3, 3'd4, 3'd5: op = picker_msg_pkg::BUF_REMOVE;
                default:          op = picker_msg_pkg::BUF_NOP;
            endcase
            drive_cycle(op, int'(r[15:0]) % (cnt_seen + 1), r[28:26] != 3'd0, 1'b0);
        end

        // runs into the full buffer
        // extra adds are dropped
        phase = "fill";
        for (int i = 0; i < 2200; i++) begin
            drive_cycle(picker_msg_pkg::BUF_ADD, 0, 1'b1, 1'b0);
        end

        // counts walk down through 1 to 0
        phase = "drain";
        for (int i = 0; i < 2200; i++) begin
            r = next_rand();
            drive_cycle(picker_msg_pkg::BUF_REMOVE,
                        int'(r[15:0]) % (cnt_seen + 1), 1'b1, 1'b0);
        end

        phase = "empty_pick";
        for (int i = 0; i < 20; i++) begin
            drive_cycle(picker_msg_pkg::BUF_NOP, 0, i[0], 1'b0);
        end
        drive_cycle(picker_msg_pkg::BUF_NOP, 0, 1'b0, 1'b1);
        repeat (10) drive_cycle(picker_msg_pkg::BUF_NOP, 0, 1'b0, 1'b0);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* list.f */
+incdir+logic
logic/sat_types_pkg.sv
logic/picker_msg_pkg.sv
logic/recip_table.sv
logic/unsat_index_selector.sv
logic/unsat_clause_buffer.sv
logic/unsat_clause_picker.sv
testbench/unsat_clause_picker_asserts.sv
testbench/unsat_clause_picker_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds the clause picker testbench with Verilator and runs it
# a nonzero exit status means the build broke or the log holds the fail message
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal -f list.f \
    --top-module unsat_clause_picker_tb -o picker_sim > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }
./obj_dir/picker_sim > sim.log 2>&1 || { echo "simulation exited with an error"; exit 1; }
grep -q "Result: FAILED" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
echo "simulation passed"
exit 0
